/* hubPkg.sv */
// Hub package with widths, FIFO depths, serial timing, counter sizes and the received byte union
package hubPkg;

        //////////////////////////////
        // Data path sizes
        //////////////////////////////
        localparam int DataBits = 8;
        localparam int NumChannels = 4;
        localparam int ChanBits = 2;                   // log2 of NumChannels
        localparam int LenBits = 4;                    // Header length field
        localparam int FifoDepthLog = 3;
        localparam int FifoEntries = 2 ** FifoDepthLog;
        localparam int CreditBits = FifoDepthLog + 1;  // Holds 0..FifoEntries

        //////////////////////////////
        // Serial timing
        //////////////////////////////
        localparam int ClksPerBit = 16;
        localparam int ClkCntBits = $clog2(ClksPerBit);

        // Receiver FSM codes
        localparam logic [1:0] RxIdle = 2'd0;
        localparam logic [1:0] RxStart = 2'd1;
        localparam logic [1:0] RxData = 2'd2;
        localparam logic [1:0] RxStop = 2'd3;

        //////////////////////////////
        // Host side
        //////////////////////////////
        localparam int HostCredits = 2;
        localparam int HostCredBits = $clog2(HostCredits + 2);  // Room for one extra grant

        // A received byte is a header or a payload byte
        typedef union packed {
                logic [DataBits-1:0] data;
                struct packed {
                        logic [ChanBits-1:0] channel;
                        logic [DataBits-ChanBits-LenBits-1:0] spare;
                        logic [LenBits-1:0] length;     // Zero means ignore
                } header;
        } rxByte_u;

endpackage

/* uartRx.sv */
// Serial 8N1 receiver with two flop line synchronizer and oversampling bit FSM
module uartRx
(
        input  logic clk,
        input  logic rst,
        input  logic serialIn,
        output logic rxValid,
        output logic [hubPkg::DataBits-1:0] rxData
);

        logic [1:0] syncReg;
        logic lineIn;
        logic lineDly;                                  // Previous synchronized level
        logic [1:0] state;
        logic [2:0] bitCount;
        logic [hubPkg::ClkCntBits-1:0] clkCount;
        logic midBit;
        logic endBit;

        assign lineIn = syncReg[1];
        assign midBit = (clkCount == hubPkg::ClkCntBits'(hubPkg::ClksPerBit / 2 - 1));
        assign endBit = (clkCount == hubPkg::ClkCntBits'(hubPkg::ClksPerBit - 1));

        // Line idles high
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        syncReg <= 2'b11;
                        lineDly <= 1'b1;
                end
                else
                begin
                        syncReg <= {syncReg[0], serialIn};
                        lineDly <= lineIn;
                end
        end

        //////////////////////////////
        // Bit timing FSM
        //////////////////////////////
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state <= hubPkg::RxIdle;
                        bitCount <= '0;
                        clkCount <= '0;
                        rxValid <= 1'b0;
                end
                else
                begin
                        rxValid <= 1'b0;
                        clkCount <= clkCount + hubPkg::ClkCntBits'(1);
                        case (state)
                                hubPkg::RxIdle:
                                begin
                                        clkCount <= '0;
                                        if (lineDly && !lineIn)     // Falling edge of start bit
                                                state <= hubPkg::RxStart;
                                end
                                hubPkg::RxStart:
                                begin
                                        if (midBit)
                                        begin
                                                clkCount <= '0;
                                                bitCount <= '0;
                                                // A high line at mid bit was only a glitch
                                                state <= lineIn ? hubPkg::RxIdle : hubPkg::RxData;
                                        end
                                end
                                hubPkg::RxData:
                                begin
                                        if (endBit)
                                        begin
                                                clkCount <= '0;
                                                bitCount <= bitCount + 3'd1;
                                                if (bitCount == 3'(hubPkg::DataBits - 1))
                                                        state <= hubPkg::RxStop;
                                        end
                                end
                                default:
                                begin
                                        if (endBit)
                                        begin
                                                rxValid <= lineIn;  // Low stop bit drops the byte
                                                state <= hubPkg::RxIdle;
                                        end
                                end
                        endcase
                end
        end

        // LSB arrives first
        always_ff @(posedge clk)
        begin
                if (state == hubPkg::RxData && endBit)
                        rxData <= {lineIn, rxData[hubPkg::DataBits-1:1]};
        end

endmodule

/* packetSteer.sv */
// Packet header parser, channel router, per channel credit counters and sticky overflow flags
module packetSteer
(
        input  logic clk,
        input  logic rst,
        input  logic rxValid,
        input  logic [hubPkg::DataBits-1:0] rxData,
        input  logic [hubPkg::NumChannels-1:0] creditReturn,
        output logic [hubPkg::NumChannels-1:0] pushValid,
        output logic [hubPkg::DataBits-1:0] pushData,
        output logic [hubPkg::NumChannels-1:0] overflow
);

        hubPkg::rxByte_u rxByte;
        logic [hubPkg::LenBits-1:0] remaining;          // Payload bytes still expected
        logic [hubPkg::ChanBits-1:0] curChannel;
        logic [hubPkg::CreditBits-1:0] credit [hubPkg::NumChannels];
        logic [hubPkg::NumChannels-1:0] take;
        logic [hubPkg::NumChannels-1:0] drop;
        logic isPayload;

        assign rxByte.data = rxData;
        assign isPayload = rxValid && (remaining != '0);

        // A payload byte either spends a credit or is lost
        always_comb
        begin
                take = '0;
                drop = '0;
                if (isPayload)
                begin
                        if (credit[curChannel] != '0)
                                take[curChannel] = 1'b1;
                        else
                                drop[curChannel] = 1'b1;
                end
        end

        //////////////////////////////
        // Header parsing
        //////////////////////////////
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        remaining <= '0;
                        curChannel <= '0;
                end
                else if (isPayload)
                        remaining <= remaining - hubPkg::LenBits'(1);
                else if (rxValid)
                begin
                        curChannel <= rxByte.header.channel;
                        remaining <= rxByte.header.length;  // Length 0 leaves us waiting for a header
                end
        end

        // Credits and overflow per channel
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        pushValid <= '0;
                        overflow <= '0;
                        for (int i = 0; i < hubPkg::NumChannels; i++)
                                credit[i] <= hubPkg::CreditBits'(hubPkg::FifoEntries);
                end
                else
                begin
                        pushValid <= take;
                        for (int i = 0; i < hubPkg::NumChannels; i++)
                        begin
                                credit[i] <= credit[i] + hubPkg::CreditBits'(creditReturn[i])
                                             - hubPkg::CreditBits'(take[i]);
                                if (drop[i])
                                        overflow[i] <= 1'b1;
                                else if (creditReturn[i])
                                        overflow[i] <= 1'b0;    // Space freed up again
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (isPayload)
                        pushData <= rxByte.data;
        end

endmodule

/* rxFifo.sv */
// Channel receive FIFO with registered empty and half-full flags and pop credit return
module rxFifo
(
        input  logic clk,
        input  logic rst,
        input  logic pushValid,
        input  logic [hubPkg::DataBits-1:0] pushData,
        input  logic pop,
        output logic [hubPkg::DataBits-1:0] headData,
        output logic fifoEmpty,
        output logic fifoHalfFull,
        output logic creditReturn
);

        logic [hubPkg::DataBits-1:0] fifoMem [hubPkg::FifoEntries];
        logic [hubPkg::FifoDepthLog-1:0] rdPtr;
        logic [hubPkg::FifoDepthLog-1:0] wrPtr;
        logic [hubPkg::CreditBits-1:0] count;
        logic [hubPkg::CreditBits-1:0] countNext;
        logic doPop;

        // Upstream credits guarantee room for every push
        assign doPop = pop && !fifoEmpty;
        assign countNext = count + hubPkg::CreditBits'(pushValid) - hubPkg::CreditBits'(doPop);
        assign headData = fifoMem[rdPtr];

        always_ff @(posedge clk)
        begin
                if (pushValid)
                        fifoMem[wrPtr] <= pushData;
        end

        //////////////////////////////
        // Pointers and flags
        //////////////////////////////
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        rdPtr <= '0;
                        wrPtr <= '0;
                        count <= '0;
                        fifoEmpty <= 1'b1;
                        fifoHalfFull <= 1'b0;
                        creditReturn <= 1'b0;
                end
                else
                begin
                        if (pushValid)
                                wrPtr <= wrPtr + hubPkg::FifoDepthLog'(1);
                        if (doPop)
                                rdPtr <= rdPtr + hubPkg::FifoDepthLog'(1);
                        count <= countNext;
                        fifoEmpty <= (countNext == '0);
                        // At least half the entries in use
                        fifoHalfFull <= (countNext >= hubPkg::CreditBits'(hubPkg::FifoEntries / 2));
                        creditReturn <= doPop;          // One credit back per byte read
                end
        end

endmodule

/* drainArbiter.sv */
// Round-robin drain of the channel FIFOs to the host port under host credits
module drainArbiter
(
        input  logic clk,
        input  logic rst,
        input  logic [hubPkg::NumChannels-1:0] fifoEmpty,
        input  logic [hubPkg::NumChannels*hubPkg::DataBits-1:0] headData,
        input  logic hostCredit,
        output logic [hubPkg::NumChannels-1:0] pop,
        output logic outValid,
        output logic [hubPkg::DataBits-1:0] outData,
        output logic [hubPkg::ChanBits-1:0] outChannel
);

        logic [hubPkg::HostCredBits-1:0] credits;
        logic [hubPkg::HostCredBits-1:0] creditNext;
        logic [hubPkg::ChanBits-1:0] lastServed;
        logic [hubPkg::ChanBits-1:0] cand;
        logic [hubPkg::ChanBits-1:0] pick;
        logic found;

        //////////////////////////////
        // Pick next busy channel
        //////////////////////////////
        always_comb
        begin
                found = 1'b0;
                pick = lastServed;
                cand = lastServed;
                for (int k = 1; k <= hubPkg::NumChannels; k++)
                begin
                        cand = lastServed + hubPkg::ChanBits'(k);   // Wraps around
                        if (!found && !fifoEmpty[cand] && credits != '0)
                        begin
                                found = 1'b1;
                                pick = cand;
                        end
                end
                pop = '0;
                if (found)
                        pop[pick] = 1'b1;
        end

        assign creditNext = credits + hubPkg::HostCredBits'(hostCredit)
                            - hubPkg::HostCredBits'(found);

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        credits <= hubPkg::HostCredBits'(hubPkg::HostCredits);
                        lastServed <= hubPkg::ChanBits'(hubPkg::NumChannels - 1);  // Channel 0 first
                        outValid <= 1'b0;
                end
                else
                begin
                        // Extra grants beyond the limit are ignored
                        if (creditNext > hubPkg::HostCredBits'(hubPkg::HostCredits))
                                credits <= hubPkg::HostCredBits'(hubPkg::HostCredits);
                        else
                                credits <= creditNext;
                        if (found)
                                lastServed <= pick;
                        outValid <= found;
                end
        end

        always_ff @(posedge clk)
        begin
                if (found)
                begin
                        outData <= headData[pick*hubPkg::DataBits +: hubPkg::DataBits];
                        outChannel <= pick;
                end
        end

endmodule

/* hubTop.sv */
// Top level of the serial receive hub with receiver, steering, channel FIFOs and drain
module hubTop
(
        input  logic clk,
        input  logic rst,
        input  logic serialIn,
        input  logic hostCredit,
        output logic outValid,
        output logic [hubPkg::DataBits-1:0] outData,
        output logic [hubPkg::ChanBits-1:0] outChannel,
        output logic [hubPkg::NumChannels-1:0] overflow,
        output logic [hubPkg::NumChannels-1:0] fifoEmpty,
        output logic [hubPkg::NumChannels-1:0] fifoHalfFull
);

        logic rxValid;
        logic [hubPkg::DataBits-1:0] rxData;
        logic [hubPkg::NumChannels-1:0] pushValid;
        logic [hubPkg::DataBits-1:0] pushData;
        logic [hubPkg::NumChannels-1:0] creditReturn;
        logic [hubPkg::NumChannels-1:0] pop;
        logic [hubPkg::NumChannels*hubPkg::DataBits-1:0] headData;  // Channel 0 in the low byte

        uartRx uartRx0
        (
                .clk(clk),
                .rst(rst),
                .serialIn(serialIn),
                .rxValid(rxValid),
                .rxData(rxData)
        );

        packetSteer packetSteer0
        (
                .clk(clk),
                .rst(rst),
                .rxValid(rxValid),
                .rxData(rxData),
                .creditReturn(creditReturn),
                .pushValid(pushValid),
                .pushData(pushData),
                .overflow(overflow)
        );

        //////////////////////////////
        // One FIFO per channel
        //////////////////////////////
        for (genvar i = 0; i < hubPkg::NumChannels; i++)
        begin : gChan
                rxFifo rxFifo0
                (
                        .clk(clk),
                        .rst(rst),
                        .pushValid(pushValid[i]),
                        .pushData(pushData),
                        .pop(pop[i]),
                        .headData(headData[i*hubPkg::DataBits +: hubPkg::DataBits]),
                        .fifoEmpty(fifoEmpty[i]),
                        .fifoHalfFull(fifoHalfFull[i]),
                        .creditReturn(creditReturn[i])
                );
        end

        drainArbiter drainArbiter0
        (
                .clk(clk),
                .rst(rst),
                .fifoEmpty(fifoEmpty),
                .headData(headData),
                .hostCredit(hostCredit),
                .pop(pop),
                .outValid(outValid),
                .outData(outData),
                .outChannel(outChannel)
        );

endmodule

/* hubTop_properties.sv */
// Bound assertions on host credit use, one-hot push select and FIFO flag consistency
module hubTopProperties
(
        input logic clk,
        input logic rst,
        input logic hostCredit,
        input logic outValid,
        input logic [hubPkg::NumChannels-1:0] pop,
        input logic [hubPkg::NumChannels-1:0] pushValid,
        input logic [hubPkg::NumChannels-1:0] fifoEmpty,
        input logic [hubPkg::NumChannels-1:0] fifoHalfFull
);

        int hostAvail;                                  // Host credits the drain block may spend
        int availNext;

        assign availNext = hostAvail + int'(hostCredit) - int'(|pop);

        always_ff @(posedge clk)
        begin
                if (rst)
                        hostAvail <= hubPkg::HostCredits;
                else if (availNext > hubPkg::HostCredits)
                        hostAvail <= hubPkg::HostCredits;
                else
                        hostAvail <= availNext;
        end

        //////////////////////////////
        // Checks
        //////////////////////////////
        creditHeld: assert property (@(posedge clk) disable iff (rst)
                outValid |-> $past(hostAvail) > 0)
                else $error("outValid raised with no host credit");

        pushOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(pushValid))
                else $error("more than one channel pushed in a cycle");

        flagsApart: assert property (@(posedge clk) disable iff (rst)
                (fifoEmpty & fifoHalfFull) == '0)
                else $error("FIFO flagged empty and half-full together");

endmodule

bind hubTop hubTopProperties props0
(
        .clk(clk),
        .rst(rst),
        .hostCredit(hostCredit),
        .outValid(outValid),
        .pop(pop),
        .pushValid(pushValid),
        .fifoEmpty(fifoEmpty),
        .fifoHalfFull(fifoHalfFull)
);

/* hubTb.sv */
// Testbench for the serial receive hub with serial driver, LFSR, reference model and output checker
module hubTb;

        logic clk = 1'b0;
        logic rst;
        logic serialIn;
        logic hostCredit = 1'b0;
        logic outValid;
        logic [hubPkg::DataBits-1:0] outData;
        logic [hubPkg::ChanBits-1:0] outChannel;
        logic [hubPkg::NumChannels-1:0] overflow;
        logic [hubPkg::NumChannels-1:0] fifoEmpty;
        logic [hubPkg::NumChannels-1:0] fifoHalfFull;

        logic [hubPkg::DataBits-1:0] expQ [hubPkg::NumChannels][$];  // Expected bytes per channel
        logic [hubPkg::DataBits-1:0] want;
        logic [31:0] lfsrState = 32'h8a85;
        logic [31:0] gapState = 32'h8a85;
        int creditMode = 0;                             // 0 none, 1 every cycle, 2 random gaps
        int gapLeft = 0;
        int outCount = 0;
        int checkErrors = 0;
        int dataErrors = 0;
        int timeouts = 0;
        int base;
        int r;
        logic [hubPkg::ChanBits-1:0] ch;
        logic [hubPkg::LenBits-1:0] len;

        hubTop dut0
        (
                .clk(clk),
                .rst(rst),
                .serialIn(serialIn),
                .hostCredit(hostCredit),
                .outValid(outValid),
                .outData(outData),
                .outChannel(outChannel),
                .overflow(overflow),
                .fifoEmpty(fifoEmpty),
                .fifoHalfFull(fifoHalfFull)
        );

        always #50 clk = ~clk;

        //////////////////////////////
        // Random numbers and reference
        //////////////////////////////
        // Taps 32, 22, 2 and 1
        function automatic logic [31:0] lfsrStep(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [7:0] takeBits(input int n);
                logic [7:0] v;
                v = '0;
                for (int k = 0; k < n; k++)
                begin
                        lfsrState = lfsrStep(lfsrState);
                        v = {v[6:0], lfsrState[0]};
                end
                return v;
        endfunction

        // Expected channel in the top two bits with the payload below
        function automatic logic [9:0] refEntry(input hubPkg::rxByte_u hdr,
                                                input logic [hubPkg::DataBits-1:0] payload);
                return {hdr.header.channel, payload};
        endfunction

        function automatic logic queuesEmpty();
                logic empty;
                empty = 1'b1;
                for (int c = 0; c < hubPkg::NumChannels; c++)
                        if (expQ[c].size() != 0)
                                empty = 1'b0;
                return empty;
        endfunction

        //////////////////////////////
        // Serial and host drivers
        //////////////////////////////
        task automatic sendByte(input logic [hubPkg::DataBits-1:0] b);
                logic [9:0] frame;
                frame = {1'b1, b, 1'b0};               // Stop, data LSB first, start
                for (int k = 0; k < 10; k++)
                begin
                        serialIn = frame[k];
                        repeat (hubPkg::ClksPerBit) @(negedge clk);
                end
        endtask

        // Only the first keep payload bytes are expected to survive
        task automatic sendPacket(input logic [hubPkg::ChanBits-1:0] chan,
                                  input logic [hubPkg::LenBits-1:0] length, input int keep);
                hubPkg::rxByte_u hdr;
                logic [hubPkg::DataBits-1:0] payload;
                logic [9:0] entry;
                hdr.data = '0;
                hdr.header.channel = chan;
                hdr.header.length = length;
                sendByte(hdr.data);
                for (int k = 0; k < int'(length); k++)
                begin
                        payload = takeBits(8);
                        entry = refEntry(hdr, payload);
                        if (k < keep)
                                expQ[entry[9:8]].push_back(entry[7:0]);
                        sendByte(payload);
                end
        endtask

        always @(negedge clk)
        begin
                if (creditMode == 1)
                        hostCredit = 1'b1;
                else if (creditMode == 2)
                begin
                        if (gapLeft == 0)
                        begin
                                hostCredit = 1'b1;
                                for (int k = 0; k < 3; k++)
                                begin
                                        gapState = lfsrStep(gapState);
                                        gapLeft = gapLeft * 2 + int'(gapState[0]);
                                end
                        end
                        else
                        begin
                                hostCredit = 1'b0;
                                gapLeft = gapLeft - 1;
                        end
                end
                else
                        hostCredit = 1'b0;
        end

        //////////////////////////////
        // Bounded waits
        //////////////////////////////
        task automatic waitDrained(input int limit);
                int n;
                n = 0;
                while (!queuesEmpty() && n < limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!queuesEmpty())
                begin
                        timeouts++;
                        $display("Timed out at %0t waiting for the expected bytes to arrive",
                                 $time);
                end
        endtask

        task automatic waitOverflowSet(input logic [hubPkg::ChanBits-1:0] chan, input int limit);
                int n;
                n = 0;
                while (!overflow[chan] && n < limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!overflow[chan])
                begin
                        timeouts++;
                        $display("Timed out at %0t waiting for overflow on channel %0d", $time, chan);
                end
        endtask

        task automatic waitFifoEmpty(input logic [hubPkg::ChanBits-1:0] chan, input int limit);
                int n;
                n = 0;
                while (!fifoEmpty[chan] && n < limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!fifoEmpty[chan])
                begin
                        timeouts++;
                        $display("Timed out at %0t waiting for FIFO %0d to empty", $time, chan);
                end
        endtask

        // Output checker samples away from the rising edge
        always @(negedge clk)
        begin
                if (!rst && outValid)
                begin
                        outCount = outCount + 1;
                        if (expQ[outChannel].size() == 0)
                        begin
                                dataErrors++;
                                $display("Error at %0t: unexpected byte %h on channel %0d",
                                         $time, outData, outChannel);
                        end
                        else
                        begin
                                want = expQ[outChannel].pop_front();
                                if (outData !== want)
                                begin
                                        dataErrors++;
                                        $display("Error at %0t: channel %0d got %h, expected %h",
                                                 $time, outChannel, outData, want);
                                end
                        end
                end
        end

        initial
        begin
                rst = 1'b1;
                serialIn = 1'b1;
                repeat (8) @(negedge clk);
                rst = 1'b0;
                @(negedge clk);
                if (outValid !== 1'b0 || overflow !== '0 || fifoEmpty !== '1)
                begin
                        checkErrors++;
                        $display("Error at %0t: wrong state after reset", $time);
                end

                creditMode = 1;
                sendPacket(2'd3, 4'd5, 5);              // Single packet
                waitDrained(2000);

                creditMode = 2;
                for (int p = 0; p < 12; p++)
                begin
                        ch = hubPkg::ChanBits'(takeBits(2));
                        r = int'(takeBits(3));
                        len = 4'(r % 6 + 1);
                        sendPacket(ch, len, int'(len));
                end
                waitDrained(4000);
                if (overflow !== '0)
                begin
                        checkErrors++;
                        $display("Error at %0t: overflow %b during random traffic", $time, overflow);
                end

                //////////////////////////////
                // Back-pressure on channel 1
                //////////////////////////////
                creditMode = 1;
                repeat (4) @(negedge clk);             // Host credits back to full
                creditMode = 0;
                base = outCount;
                sendPacket(2'd1, 4'd12, hubPkg::HostCredits + hubPkg::FifoEntries);
                waitOverflowSet(2'd1, 500);
                if (outCount - base != hubPkg::HostCredits)
                begin
                        checkErrors++;
                        $display("Error at %0t: %0d bytes delivered without credits", $time,
                                 outCount - base);
                end
                if (fifoHalfFull[1] !== 1'b1)
                begin
                        checkErrors++;
                        $display("Error at %0t: FIFO 1 not half-full under back-pressure", $time);
                end
                creditMode = 1;
                waitDrained(2000);
                waitFifoEmpty(2'd1, 200);
                if (overflow[1] !== 1'b0)
                begin
                        checkErrors++;
                        $display("Error at %0t: overflow on channel 1 did not clear", $time);
                end

                base = outCount;
                sendPacket(2'd2, 4'd0, 0);              // Ignored header
                sendPacket(2'd2, 4'd2, 2);
                waitDrained(2000);
                if (outCount - base != 2)
                begin
                        checkErrors++;
                        $display("Error at %0t: %0d bytes after the empty header", $time,
                                 outCount - base);
                end

                $display("Check errors: %0d, data errors: %0d, timeouts: %0d",
                         checkErrors, dataErrors, timeouts);
                if (checkErrors == 0 && dataErrors == 0 && timeouts == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

/* build.f */
hubPkg.sv
uartRx.sv
packetSteer.sv
rxFifo.sv
drainArbiter.sv
hubTop.sv
hubTop_properties.sv
hubTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = hubTb
FILELIST  = build.f
LOG       = sim.log
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
